// ==== Makefile ====
# Verilator build and run of the SM83 ALU slice testbench.

TOP := sm83_alu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir

# The simulator exits nonzero on $fatal, so make reports the failure.
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+hw
hw/sm83_alu_pkg.sv
hw/sm83_alu_decode.sv
hw/sm83_alu_core.sv
hw/sm83_alu_flags.sv
hw/sm83_alu_unit.sv
tb/sm83_alu_assertions.sv
tb/sm83_alu_tb.sv

// ==== hw/sm83_alu_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 ALU core.
// Computes result, half carry, carry, shift out and DAA carry.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sm83_consts.svh"

module sm83_alu_core (
	input  sm83_alu_pkg::alu_stage_t  stage,
	input  sm83_alu_pkg::alu_flags_t  flags_cur,
	output logic [`SM83_DATA_W-1:0]   value,
	output logic                      zero_out,
	output logic                      half_out,
	output logic                      carry_out,
	output logic                      shift_out,
	output logic                      daa_carry_out
);
	import sm83_alu_pkg::*;

	logic                    sub;       // Adder runs as a subtractor.
	logic                    cin;       // Carry or borrow in.
	logic [`SM83_DATA_W-1:0] opnd;      // Second adder operand.
	logic [`SM83_DATA_W-1:0] opnd_x;    // Inverted for subtraction.
	logic [4:0]              lo_sum;
	logic [4:0]              hi_sum;
	logic [`SM83_DATA_W-1:0] sum;
	logic                    half_raw;
	logic                    carry_raw;
	logic [`SM83_DATA_W-1:0] daa_adj;
	logic [`SM83_DATA_W-1:0] daa_val;

	// Two nibble adders, borrow is the inverted carry.
	always_comb begin
		sub = (stage.op == SUB) || (stage.op == SBC) || (stage.op == CP) ||
			(stage.op == DEC);
		opnd = ((stage.op == INC) || (stage.op == DEC)) ? 8'h01 : stage.b;
		cin  = ((stage.op == ADC) || (stage.op == SBC)) ? flags_cur.c : 1'b0;
		opnd_x = sub ? ~opnd : opnd;
		lo_sum = {1'b0, stage.a[3:0]} + {1'b0, opnd_x[3:0]} + {4'b0, cin ^ sub};
		hi_sum = {1'b0, stage.a[7:4]} + {1'b0, opnd_x[7:4]} + {4'b0, lo_sum[4]};
		sum       = {hi_sum[3:0], lo_sum[3:0]};
		half_raw  = lo_sum[4] ^ sub; // Low nibble carry or borrow.
		carry_raw = hi_sum[4] ^ sub;
	end

	// Decimal adjust after add or subtract.
	always_comb begin
		daa_adj       = '0;
		daa_carry_out = flags_cur.c; // Carry survives unless set below.
		if (!flags_cur.n) begin
			if (flags_cur.c || (stage.a > 8'h99)) begin
				daa_adj[7:4]  = 4'h6;
				daa_carry_out = 1'b1;
			end
			if (flags_cur.h || (stage.a[3:0] > 4'h9))
				daa_adj[3:0] = 4'h6;
		end else begin
			// After a subtraction only the recorded carries count.
			if (flags_cur.c)
				daa_adj[7:4] = 4'h6;
			if (flags_cur.h)
				daa_adj[3:0] = 4'h6;
		end
		daa_val = flags_cur.n ? (stage.a - daa_adj) : (stage.a + daa_adj);
	end

	// Result and flag inputs per operation.
	always_comb begin
		value     = sum;
		half_out  = half_raw;
		carry_out = carry_raw;
		shift_out = 1'b0;
		unique case (stage.op)
			ADD, ADC, SUB, SBC, INC, DEC: ; // Adder output as is.
			CP: value = stage.a; // Only the flags change.
			AND: begin
				value     = stage.a & stage.b;
				half_out  = 1'b1;
				carry_out = 1'b0;
			end
			XOR: begin
				value     = stage.a ^ stage.b;
				half_out  = 1'b0;
				carry_out = 1'b0;
			end
			OR: begin
				value     = stage.a | stage.b;
				half_out  = 1'b0;
				carry_out = 1'b0;
			end
			RLC: begin
				value     = {stage.a[6:0], stage.a[7]};
				shift_out = stage.a[7];
				half_out  = 1'b0;
			end
			RRC: begin
				value     = {stage.a[0], stage.a[7:1]};
				shift_out = stage.a[0];
				half_out  = 1'b0;
			end
			DAA: begin
				value    = daa_val;
				half_out = 1'b0;
			end
			SCF: begin
				value     = stage.a;
				half_out  = 1'b0;
				carry_out = 1'b1;
			end
			CCF: begin
				value     = stage.a;
				half_out  = 1'b0;
				carry_out = ~flags_cur.c; // Complement of visible C.
			end
			CPL: value = ~stage.a;
			LDF: value = stage.a; // Flags come from din.
			default: value = stage.a;
		endcase
		// Compare reports zero for equal operands.
		zero_out = (stage.op == CP) ? (sum == '0) : (value == '0);
	end

endmodule

// ==== hw/sm83_alu_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 ALU decode stage.
// Captures the operation and builds the flag strobes.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sm83_consts.svh"

module sm83_alu_decode (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      op_valid,
	input  sm83_alu_pkg::alu_op_t     op,
	input  logic [`SM83_DATA_W-1:0]   a,
	input  logic [`SM83_DATA_W-1:0]   b,
	output sm83_alu_pkg::alu_stage_t  stage,
	output logic                      stage_valid
);
	import sm83_alu_pkg::*;

	flag_ctrl_t ctrl; // Strobes for the incoming opcode.

	// Opcode to flag strobe table.
	always_comb begin
		ctrl           = '0;
		ctrl.flags_alu = 1'b1; // Core drives the flags by default.
		ctrl.zero_we   = 1'b1;
		ctrl.neg_we    = 1'b1;
		ctrl.half_we   = 1'b1;
		unique case (op)
			ADD, ADC: begin
				ctrl.neg_clr  = 1'b1;
				ctrl.carry_we = 1'b1;
			end
			SUB, SBC, CP: begin
				ctrl.neg_set  = 1'b1; // Subtraction sets N.
				ctrl.carry_we = 1'b1;
			end
			AND, XOR, OR: begin
				ctrl.neg_clr  = 1'b1;
				ctrl.carry_we = 1'b1; // Core returns C = 0.
			end
			INC: ctrl.neg_clr = 1'b1; // C untouched.
			DEC: ctrl.neg_set = 1'b1;
			RLC, RRC: begin
				ctrl.neg_clr      = 1'b1;
				ctrl.sec_carry_we = 1'b1;
				ctrl.sec_carry_sh = 1'b1; // Bit rotated out.
			end
			DAA: begin
				ctrl.neg_we        = 1'b0; // N is kept.
				ctrl.sec_carry_we  = 1'b1;
				ctrl.sec_carry_daa = 1'b1;
			end
			SCF, CCF: begin
				ctrl.zero_we  = 1'b0;
				ctrl.neg_clr  = 1'b1;
				ctrl.carry_we = 1'b1;
			end
			CPL: begin
				ctrl.zero_we  = 1'b0;
				ctrl.neg_set  = 1'b1;
				ctrl.half_set = 1'b1;
			end
			LDF: begin
				// Every flag comes from the bus word.
				ctrl.flags_alu = 1'b0;
				ctrl.flags_bus = 1'b1;
				ctrl.carry_we  = 1'b1;
			end
			default: begin
				ctrl = '0; // Unused encodings touch nothing.
			end
		endcase
	end

	// Stage register, loaded once per strobe.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stage       <= '0;
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= op_valid; // One cycle in the stage.
			if (op_valid) begin
				stage.op   <= op;
				stage.a    <= a;
				stage.b    <= b;
				stage.ctrl <= ctrl;
			end
		end
	end

endmodule

// ==== hw/sm83_alu_flags.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 flag register.
// Primary and secondary carry, bus load and bus read.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sm83_consts.svh"

module sm83_alu_flags (
	input  logic                      clk,
	input  logic                      arst_n,
	input  sm83_alu_pkg::flag_ctrl_t  ctrl,
	input  logic                      update,
	input  logic [`SM83_DATA_W-1:0]   din,
	input  logic                      zero_in,
	input  logic                      half_in,
	input  logic                      carry_in,
	input  logic                      shift_out_in,
	input  logic                      daa_carry_in,
	output sm83_alu_pkg::alu_flags_t  flags,
	output logic [`SM83_DATA_W-1:0]   flags_byte,
	output logic                      pri_carry
);
	import sm83_alu_pkg::*;

	logic zero_q;
	logic neg_q;
	logic half_q;
	logic pri_c_q;  // Arithmetic carry.
	logic sec_c_q;  // Shift out or DAA carry.
	logic csrc_q;   // High selects the secondary carry.
	logic pri_we;
	logic sec_we;
	logic sec_next;

	// Bus or core source, holding the old value if neither is chosen.
	function automatic logic pick(input logic bus_bit, input logic alu_bit,
		input logic keep);
		if (ctrl.flags_bus)
			return bus_bit;
		else if (ctrl.flags_alu)
			return alu_bit;
		return keep;
	endfunction

	assign sec_we = update && ctrl.sec_carry_we;
	assign pri_we = update && ctrl.carry_we && !ctrl.sec_carry_we; // Secondary wins.

	always_comb begin
		if (ctrl.sec_carry_daa)
			sec_next = daa_carry_in;
		else if (ctrl.sec_carry_sh)
			sec_next = shift_out_in;
		else
			sec_next = pick(din[`SM83_FLAG_C], carry_in, sec_c_q);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			zero_q  <= 1'b0;
			neg_q   <= 1'b0;
			half_q  <= 1'b0;
			pri_c_q <= 1'b0;
			sec_c_q <= 1'b0;
			csrc_q  <= 1'b0;
		end else begin
			if (update && ctrl.zero_we)
				zero_q <= pick(din[`SM83_FLAG_Z], zero_in, zero_q);
			if (update && ctrl.neg_we) begin
				if (ctrl.neg_clr)
					neg_q <= 1'b0;
				else if (ctrl.neg_set)
					neg_q <= 1'b1;
				else if (ctrl.flags_bus)
					neg_q <= din[`SM83_FLAG_N]; // Core has no N.
			end
			if (update && ctrl.half_we)
				half_q <= ctrl.half_set ? 1'b1 : pick(din[`SM83_FLAG_H], half_in, half_q);
			if (pri_we)
				pri_c_q <= pick(din[`SM83_FLAG_C], carry_in, pri_c_q);
			if (sec_we)
				sec_c_q <= sec_next;
			// Last carry writer owns flags.c.
			if (sec_we)
				csrc_q <= 1'b1;
			else if (pri_we)
				csrc_q <= 1'b0;
		end
	end

	assign flags.z   = zero_q;
	assign flags.n   = neg_q;
	assign flags.h   = half_q;
	assign flags.c   = csrc_q ? sec_c_q : pri_c_q;
	assign pri_carry = pri_c_q;

	// F as seen on the data bus.
	always_comb begin
		flags_byte               = '0;
		flags_byte[`SM83_FLAG_Z] = flags.z;
		flags_byte[`SM83_FLAG_N] = flags.n;
		flags_byte[`SM83_FLAG_H] = flags.h;
		flags_byte[`SM83_FLAG_C] = flags.c;
	end

endmodule

// ==== hw/sm83_alu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 ALU types.
// Opcodes, flag controls, flags and the captured stage.
// ~~~~~~~~~~~~~~~~~~~~

`include "sm83_consts.svh"

package sm83_alu_pkg;

	// ALU operations seen by the slice.
	typedef enum logic [4:0] {
		ADD, // a + b.
		ADC, // a + b + C.
		SUB, // a - b.
		SBC, // a - b - C.
		AND,
		XOR,
		OR,
		CP,  // Compare, flags of a - b.
		INC,
		DEC,
		RLC, // Rotate left circular.
		RRC, // Rotate right circular.
		DAA, // Decimal adjust.
		SCF,
		CCF,
		CPL,
		LDF  // Load flags from the bus.
	} alu_op_t;

	// Flag update strobes from the decoder.
	typedef struct packed {
		logic flags_bus;     // Flags come from din.
		logic flags_alu;     // Flags come from the core.
		logic zero_we;
		logic neg_we;
		logic neg_set;
		logic neg_clr;
		logic half_we;
		logic half_set;      // Force H to 1.
		logic carry_we;      // Primary carry write.
		logic sec_carry_we;  // Secondary carry write, blocks the primary.
		logic sec_carry_sh;  // Secondary takes the shift out bit.
		logic sec_carry_daa; // Secondary takes the DAA carry.
	} flag_ctrl_t;

	// Architectural flags.
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} alu_flags_t;

	// One captured operation.
	typedef struct packed {
		alu_op_t                op;
		logic [`SM83_DATA_W-1:0] a;
		logic [`SM83_DATA_W-1:0] b;
		flag_ctrl_t             ctrl;
	} alu_stage_t;

endpackage

// ==== hw/sm83_alu_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 ALU slice top.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sm83_consts.svh"

module sm83_alu_unit (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      op_valid,
	input  sm83_alu_pkg::alu_op_t     op,
	input  logic [`SM83_DATA_W-1:0]   a,
	input  logic [`SM83_DATA_W-1:0]   b,
	input  logic [`SM83_DATA_W-1:0]   din,
	output logic [`SM83_DATA_W-1:0]   result,
	output logic                      result_valid,
	output sm83_alu_pkg::alu_flags_t  flags,
	output logic [`SM83_DATA_W-1:0]   flags_byte
);
	import sm83_alu_pkg::*;

	alu_stage_t              stage;
	logic                    stage_valid;
	logic [`SM83_DATA_W-1:0] value;
	logic                    zero_c, half_c, carry_c, shift_c, daa_c;
	logic                    pri_carry; // Raw primary carry, probed by checks.

	sm83_alu_decode sm83_alu_decode_inst (
		.clk, .arst_n, .op_valid, .op, .a, .b,
		.stage, .stage_valid
	);

	// Core sees the flags committed by the previous operation.
	sm83_alu_core sm83_alu_core_inst (
		.stage, .flags_cur(flags), .value,
		.zero_out(zero_c), .half_out(half_c), .carry_out(carry_c),
		.shift_out(shift_c), .daa_carry_out(daa_c)
	);

	sm83_alu_flags sm83_alu_flags_inst (
		.clk, .arst_n, .ctrl(stage.ctrl), .update(stage_valid), .din,
		.zero_in(zero_c), .half_in(half_c), .carry_in(carry_c),
		.shift_out_in(shift_c), .daa_carry_in(daa_c),
		.flags, .flags_byte, .pri_carry
	);

	// Result commits together with the flags.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result       <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= stage_valid; // Single cycle pulse per op.
			if (stage_valid)
				result <= value;
		end
	end

endmodule

// ==== hw/sm83_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 ALU constants.
// Flag byte bit positions and the data width.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef SM83_CONSTS_SVH
`define SM83_CONSTS_SVH

// Data path width of the ALU.
`define SM83_DATA_W 8

// Flag positions inside the F register byte.
`define SM83_FLAG_Z 7 // Zero.
`define SM83_FLAG_N 6 // Subtract.
`define SM83_FLAG_H 5 // Half carry.
`define SM83_FLAG_C 4 // Carry.

// Low nibble of F always reads as zero.

`endif

// ==== tb/sm83_alu_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 ALU checker, bound into the top level.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sm83_consts.svh"

module sm83_alu_assertions (
	input logic                      clk,
	input logic                      arst_n,
	input logic                      op_valid,
	input sm83_alu_pkg::alu_op_t     op,
	input logic [`SM83_DATA_W-1:0]   a,
	input logic [`SM83_DATA_W-1:0]   b,
	input logic [`SM83_DATA_W-1:0]   din,
	input logic [`SM83_DATA_W-1:0]   result,
	input logic                      result_valid,
	input sm83_alu_pkg::alu_flags_t  flags,
	input logic [`SM83_DATA_W-1:0]   flags_byte,
	input logic                      pri_carry
);
	import sm83_alu_pkg::*;

	logic check_failed = 1'b0; // Sticky, polled by the testbench.

	// SM83 result for one operation.
	function automatic logic [7:0] expect_value(input logic [4:0] o, input logic [7:0] x,
		input logic [7:0] y, input alu_flags_t f);
		logic [7:0] adj;
		adj = 8'h00;
		if (o == DAA) begin
			if (f.c || (!f.n && x > 8'h99))
				adj[7:4] = 4'h6;
			if (f.h || (!f.n && x[3:0] > 4'h9))
				adj[3:0] = 4'h6;
			return f.n ? x - adj : x + adj; // Undo the BCD overflow.
		end
		case (o)
			ADD: return x + y;
			ADC: return x + y + {7'd0, f.c};
			SUB: return x - y;
			SBC: return x - y - {7'd0, f.c};
			AND: return x & y;
			XOR: return x ^ y;
			OR:  return x | y;
			INC: return x + 8'd1;
			DEC: return x - 8'd1;
			RLC: return {x[6:0], x[7]};
			RRC: return {x[0], x[7:1]};
			CPL: return ~x;
			default: return x; // CP keeps a.
		endcase
	endfunction

	// Flags after one operation, packed as Z, N, H, C.
	function automatic alu_flags_t expect_flags(input logic [4:0] o, input logic [7:0] x,
		input logic [7:0] y, input alu_flags_t f, input logic [7:0] bus);
		alu_flags_t e;
		logic [8:0] full;
		logic [4:0] low;
		logic       cin;
		cin  = ((o == ADC) || (o == SBC)) ? f.c : 1'b0;
		full = {1'b0, x} - {1'b0, y} - {8'd0, cin}; // Borrow lands in bit 8.
		low  = {1'b0, x[3:0]} - {1'b0, y[3:0]} - {4'd0, cin};
		e    = f;
		e.z  = (expect_value(o, x, y, f) == 8'h00);
		case (o)
			ADD, ADC: begin
				full = {1'b0, x} + {1'b0, y} + {8'd0, cin};
				low  = {1'b0, x[3:0]} + {1'b0, y[3:0]} + {4'd0, cin};
				e    = {e.z, 1'b0, low[4], full[8]};
			end
			SUB, SBC, CP: e = {full[7:0] == 8'h00, 1'b1, low[4], full[8]};
			AND:     e = {e.z, 3'b010};
			XOR, OR: e = {e.z, 3'b000};
			INC:     e = {e.z, 1'b0, x[3:0] == 4'hf, f.c};
			DEC:     e = {e.z, 1'b1, x[3:0] == 4'h0, f.c};
			RLC:     e = {e.z, 2'b00, x[7]};
			RRC:     e = {e.z, 2'b00, x[0]};
			DAA:     e = {e.z, f.n, 1'b0, f.c || (!f.n && x > 8'h99)};
			SCF:     e = {f.z, 3'b001};
			CCF:     e = {f.z, 2'b00, !f.c};
			CPL:     e = {f.z, 2'b11, f.c};
			LDF: e = {bus[`SM83_FLAG_Z], bus[`SM83_FLAG_N], bus[`SM83_FLAG_H], bus[`SM83_FLAG_C]};
			default: e = f;
		endcase
		return e;
	endfunction

	function automatic logic writes_secondary(input logic [4:0] o);
		return (o == RLC) || (o == RRC) || (o == DAA);
	endfunction

	function automatic logic writes_primary(input logic [4:0] o);
		return !(writes_secondary(o) || (o == INC) || (o == DEC) || (o == CPL));
	endfunction

	// Flag only ops have no defined result.
	function automatic logic value_defined(input logic [4:0] o);
		return !((o == SCF) || (o == CCF) || (o == LDF));
	endfunction

	a_reset_clear: assert property (@(posedge clk)
		(!arst_n || !$past(arst_n)) |-> (!result_valid && flags == '0 && result == '0))
		else begin
			$error("result, result_valid or flags not cleared by reset");
			check_failed = 1'b1;
		end

	a_valid_delay: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid == $past(op_valid, 2))
		else begin
			$error("ERROR %0t result_valid %0b expected %0b", $time, result_valid,
				$past(op_valid, 2));
			check_failed = 1'b1;
		end

	a_result: assert property (@(posedge clk) disable iff (!arst_n)
		(result_valid && value_defined($past(op, 2))) |->
		result == expect_value($past(op, 2), $past(a, 2), $past(b, 2), $past(flags)))
		else begin
			$error("ERROR %0t result 0x%02h expected 0x%02h for op %0d", $time, result,
				expect_value($past(op, 2), $past(a, 2), $past(b, 2), $past(flags)),
				$past(op, 2));
			check_failed = 1'b1;
		end

	a_flags: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |-> flags == expect_flags($past(op, 2), $past(a, 2), $past(b, 2),
		$past(flags), $past(din)))
		else begin
			$error("ERROR %0t flags 0x%01h expected 0x%01h for op %0d", $time, flags,
				expect_flags($past(op, 2), $past(a, 2), $past(b, 2), $past(flags),
				$past(din)), $past(op, 2));
			check_failed = 1'b1;
		end

	a_flags_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!result_valid |-> flags == $past(flags))
		else begin
			$error("ERROR %0t flags 0x%01h expected 0x%01h", $time, flags, $past(flags));
			check_failed = 1'b1;
		end

	// Shifts and DAA leave the arithmetic carry alone.
	a_primary_kept: assert property (@(posedge clk) disable iff (!arst_n)
		(result_valid && writes_secondary($past(op, 2))) |-> pri_carry == $past(pri_carry))
		else begin
			$error("ERROR %0t pri_carry %0b expected %0b", $time, pri_carry,
				$past(pri_carry));
			check_failed = 1'b1;
		end

	a_primary_shown: assert property (@(posedge clk) disable iff (!arst_n)
		(result_valid && writes_primary($past(op, 2))) |-> flags.c == pri_carry)
		else begin
			$error("ERROR %0t flags.c %0b expected %0b", $time, flags.c, pri_carry);
			check_failed = 1'b1;
		end

	a_flags_byte: assert property (@(posedge clk)
		flags_byte[3:0] == 4'h0 && flags_byte[`SM83_FLAG_Z] == flags.z &&
		flags_byte[`SM83_FLAG_N] == flags.n && flags_byte[`SM83_FLAG_H] == flags.h &&
		flags_byte[`SM83_FLAG_C] == flags.c)
		else begin
			$error("ERROR %0t flags_byte 0x%02h expected 0x%02h", $time, flags_byte,
				{flags, 4'h0});
			check_failed = 1'b1;
		end

endmodule

// ==== tb/sm83_alu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SM83 ALU testbench.
// Directed then random operations, back to back and with gaps.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sm83_consts.svh"

module sm83_alu_tb;
	import sm83_alu_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_OPS   = 300;
	localparam int DRAIN_LIMIT  = 20; // Two stages, plenty of slack.

	logic                    clk;
	logic                    arst_n;
	logic                    op_valid;
	alu_op_t                 op;
	logic [`SM83_DATA_W-1:0] a;
	logic [`SM83_DATA_W-1:0] b;
	logic [`SM83_DATA_W-1:0] din;
	logic [`SM83_DATA_W-1:0] result;
	logic                    result_valid;
	alu_flags_t              flags;
	logic [`SM83_DATA_W-1:0] flags_byte;
	logic [15:0]             lfsr;
	int                      ops_issued;
	int                      results_seen;

	// Every opcode once, shifts and DAA followed by carry users.
	alu_op_t directed [0:27] = '{
		ADD, DAA, RLC, ADD, RRC, SBC, SUB, DAA, ADC, AND, XOR, OR, CP, INC,
		DEC, SCF, CCF, CCF, CPL, LDF, ADC, LDF, RLC, INC, DEC, DAA, SBC, ADD
	};

	sm83_alu_unit sm83_alu_unit_inst (
		.clk, .arst_n, .op_valid, .op, .a, .b, .din,
		.result, .result_valid, .flags, .flags_byte
	);

	bind sm83_alu_unit sm83_alu_assertions sm83_alu_assertions_inst (
		.clk, .arst_n, .op_valid, .op, .a, .b, .din,
		.result, .result_valid, .flags, .flags_byte, .pri_carry
	);

	always #50 clk = ~clk; // 100 ns period.

	always @(posedge clk) begin
		if (result_valid)
			results_seen <= results_seen + 1;
	end

	// A failed bound assertion ends the run.
	always @(negedge clk) begin
		if (sm83_alu_unit_inst.sm83_alu_assertions_inst.check_failed) begin
			$display("TEST FAILED");
			$fatal(1, "A bound assertion failed, see the error above");
		end
	end

	// Fibonacci LFSR, taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int count, output logic [7:0] bits);
		bits = 8'h00;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_step(lfsr); // One step per bit.
			bits = {bits[6:0], lfsr[0]};
		end
	endtask

	// Advance to 1 ns after the next rising edge, new bus word each cycle.
	task automatic next_cycle();
		logic [7:0] bits;
		@(posedge clk);
		#1;
		take_bits(8, bits);
		din = bits;
	endtask

	task automatic issue(input alu_op_t code);
		logic [7:0] bits;
		op_valid = 1'b1;
		op       = code;
		take_bits(8, bits);
		a = bits;
		take_bits(8, bits);
		b = bits;
		ops_issued++;
		next_cycle();
		op_valid = 1'b0;
	endtask

	task automatic idle(input int cycles);
		op_valid = 1'b0;
		repeat (cycles) next_cycle();
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (results_seen != ops_issued) begin
			if (cycles == DRAIN_LIMIT) begin
				$display("TEST FAILED");
				$fatal(1, "Timed out waiting for the last results to leave the ALU");
			end
			next_cycle();
			cycles++;
		end
	endtask

	initial begin
		logic [7:0] bits;
		clk          = 1'b0;
		arst_n       = 1'b0;
		op_valid     = 1'b0;
		op           = ADD;
		a            = '0;
		b            = '0;
		din          = '0;
		lfsr         = 16'd90; // Seed.
		ops_issued   = 0;
		results_seen = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		idle(2);
		foreach (directed[i])
			issue(directed[i]); // Back to back.
		idle(3);
		for (int n = 0; n < RANDOM_OPS; n++) begin
			take_bits(5, bits);
			issue(alu_op_t'(bits[4:0] % 5'd17));
			take_bits(2, bits);
			idle(bits[1:0] == 2'b11 ? 2 : 0); // Occasional gap.
		end
		wait_drained();
		idle(3);
		if (sm83_alu_unit_inst.sm83_alu_assertions_inst.check_failed) begin
			$display("TEST FAILED");
			$fatal(1, "A bound assertion failed near the end of the run");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule
